// File: logic/net_tx_pkg.sv
/* net tx shared definitions
   protocol enum, header sizes, address types and header constants */
package net_tx_pkg;

  // ------------------------------
  // traffic class
  // ------------------------------

  // one frame in flight, so a single bit is enough
  typedef enum logic
  {
    PROTO_ARP,
    PROTO_UDP
  } proto_e;

  // ------------------------------
  // field types
  // ------------------------------

  // ethernet station address
  typedef logic [47:0] mac_addr_t;

  // ipv4 address, network byte order
  typedef logic [31:0] ip_addr_t;

  // udp port
  typedef logic [15:0] port_t;

  // byte counts and length fields
  typedef logic [15:0] len_t;

  // ------------------------------
  // header sizes in bytes
  // ------------------------------

  // dest mac + src mac + ethertype
  localparam int MAC_HDR_LEN = 14;

  // ipv4 without options
  localparam int IP_HDR_LEN = 20;

  // ports, length, checksum
  localparam int UDP_HDR_LEN = 8;

  // arp body for ipv4 over ethernet
  localparam int ARP_BODY_LEN = 28;

  // ------------------------------
  // protocol constants
  // ------------------------------

  localparam logic [15:0] ETHERTYPE_IP = 16'h0800;
  localparam logic [15:0] ETHERTYPE_ARP = 16'h0806;

  // time to live of every sent datagram
  localparam logic [7:0] IP_TTL = 8'h80;

  // ip protocol number of udp
  localparam logic [7:0] IP_PROTO_UDP = 8'd17;

endpackage

// File: logic/tx_arbiter.sv
/* tx arbiter, grants ARP ahead of UDP, holds the destination fields
   and steers payload pulls between the MAC framer and the chosen source */
`timescale 1ns/1ps

module tx_arbiter
(
  input  logic                   tx_clock,
  input  logic                   rst_n,
  input  logic                   arp_request,
  input  net_tx_pkg::mac_addr_t  arp_dest_mac,
  input  logic [7:0]             arp_data,
  input  logic                   udp_request,
  input  net_tx_pkg::len_t       udp_length,
  input  net_tx_pkg::ip_addr_t   udp_dest_ip,
  input  net_tx_pkg::mac_addr_t  udp_dest_mac,
  input  net_tx_pkg::port_t      udp_dest_port,
  input  logic [7:0]             udp_data,
  input  logic                   udp_pull,
  input  logic [7:0]             ip_body_data,
  input  logic                   ip_body_last,
  input  logic                   frame_pull,
  input  logic                   frame_done,
  output logic                   arp_grant,
  output logic                   arp_advance,
  output logic                   udp_grant,
  output logic                   udp_advance,
  output logic                   frame_start,
  output logic [15:0]            frame_ethertype,
  output net_tx_pkg::mac_addr_t  frame_dest_mac,
  output logic [7:0]             frame_body_data,
  output logic                   frame_body_last,
  output net_tx_pkg::ip_addr_t   dest_ip,
  output net_tx_pkg::port_t      dest_port,
  output net_tx_pkg::len_t       payload_length,
  output logic [7:0]             payload_data,
  output logic                   ip_start,
  output logic                   ip_pull
);
  import net_tx_pkg::*;

  typedef enum logic
  {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_e;

  arb_state_e state;
  proto_e     proto;
  logic [5:0] arp_cnt;
  logic       is_arp;
  logic       busy;

  assign is_arp = (proto == PROTO_ARP);
  assign busy = (state == ARB_BUSY);

  // ------------------------------
  // grant and frame ownership
  // ------------------------------
  always_ff @(posedge tx_clock)
  begin
    if (!rst_n)
    begin
      state <= ARB_IDLE;
      proto <= PROTO_ARP;
      arp_grant <= 1'b0;
      udp_grant <= 1'b0;
      arp_cnt <= '0;
    end
    else
    begin
      // grants are single cycle pulses
      arp_grant <= 1'b0;
      udp_grant <= 1'b0;
      if (state == ARB_IDLE)
      begin
        arp_cnt <= '0;
        // arp wins a tie
        if (arp_request)
        begin
          state <= ARB_BUSY;
          proto <= PROTO_ARP;
          arp_grant <= 1'b1;
        end
        else if (udp_request)
        begin
          state <= ARB_BUSY;
          proto <= PROTO_UDP;
          udp_grant <= 1'b1;
        end
      end
      else
      begin
        // arp body position, for the last flag
        if (arp_advance)
          arp_cnt <= arp_cnt + 6'd1;
        // free once the framer has sent the final byte
        if (frame_done)
          state <= ARB_IDLE;
      end
    end
  end

  // per frame fields, taken on the grant edge
  always_ff @(posedge tx_clock)
  begin
    if (state == ARB_IDLE && arp_request)
      frame_dest_mac <= arp_dest_mac;
    else if (state == ARB_IDLE && udp_request)
    begin
      frame_dest_mac <= udp_dest_mac;
      dest_ip <= udp_dest_ip;
      dest_port <= udp_dest_port;
      payload_length <= udp_length;
    end
  end

  // ------------------------------
  // stream routing
  // ------------------------------
  assign frame_start = arp_grant | udp_grant;
  assign ip_start = udp_grant;
  assign frame_ethertype = is_arp ? ETHERTYPE_ARP : ETHERTYPE_IP;

  // arp bytes go straight to the framer, udp through the ip chain
  assign frame_body_data = is_arp ? arp_data : ip_body_data;
  assign frame_body_last = is_arp ? (arp_cnt == 6'(ARP_BODY_LEN - 1)) : ip_body_last;

  // pulls only reach the owner of the current frame
  assign arp_advance = busy & is_arp & frame_pull;
  assign ip_pull = busy & ~is_arp & frame_pull;
  assign udp_advance = busy & ~is_arp & udp_pull;
  assign payload_data = udp_data;

  // no second grant until the framer reports the end of the frame
  a_grant_busy: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (arp_grant || udp_grant) |=> !(arp_grant || udp_grant) until_with frame_done);

endmodule

// File: logic/udp_header.sv
/* UDP header stage, emits the 8 byte header with a zero checksum
   and then passes the payload bytes pulled from the source */
`timescale 1ns/1ps

module udp_header
#(
  parameter net_tx_pkg::port_t LOCAL_PORT = 16'd1024
)
(
  input  logic               tx_clock,
  input  logic               rst_n,
  input  logic               start,
  input  net_tx_pkg::len_t   payload_length,
  input  net_tx_pkg::port_t  dest_port,
  input  logic [7:0]         payload_data,
  input  logic               pull,
  output logic [7:0]         seg_data,
  output logic               seg_last,
  output net_tx_pkg::len_t   seg_length,
  output logic               payload_advance
);
  import net_tx_pkg::*;

  typedef enum logic [1:0]
  {
    UDP_IDLE,
    UDP_HDR,
    UDP_PAYLOAD
  } udp_state_e;

  udp_state_e  state;
  len_t        idx;
  logic [63:0] hdr;
  logic        in_payload;

  // segment length covers header and payload
  assign seg_length = payload_length + 16'(UDP_HDR_LEN);

  // src port, dst port, length, checksum left at zero
  assign hdr = {LOCAL_PORT, dest_port, seg_length, 16'h0000};

  assign in_payload = (state == UDP_PAYLOAD);
  assign seg_data = in_payload ? payload_data : hdr[8*(7 - idx[2:0]) +: 8];
  assign seg_last = in_payload && (idx == payload_length - 16'd1);

  // payload moves in step with the ip stage
  assign payload_advance = in_payload & pull;

  always_ff @(posedge tx_clock)
  begin
    if (!rst_n)
    begin
      state <= UDP_IDLE;
      idx <= '0;
    end
    else if (start)
    begin
      state <= UDP_HDR;
      idx <= '0;
    end
    else if (pull)
    begin
      // header done, count restarts for the payload
      if (state == UDP_HDR && idx == 16'(UDP_HDR_LEN - 1))
      begin
        state <= UDP_PAYLOAD;
        idx <= '0;
      end
      else if (seg_last)
        state <= UDP_IDLE;
      else
        idx <= idx + 16'd1;
    end
  end

  // ip stage stops pulling once the segment has ended
  a_no_pull_idle: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (state == UDP_IDLE) |-> !pull);

endmodule

// File: logic/ip_header.sv
/* IPv4 header stage, emits the 20 byte header with identification
   and header checksum, then passes the UDP segment through */
`timescale 1ns/1ps

module ip_header
#(
  parameter net_tx_pkg::ip_addr_t LOCAL_IP = 32'hc0a8_010a
)
(
  input  logic                  tx_clock,
  input  logic                  rst_n,
  input  logic                  start,
  input  net_tx_pkg::len_t      seg_length,
  input  net_tx_pkg::ip_addr_t  dest_ip,
  input  logic [7:0]            seg_data,
  input  logic                  seg_last,
  input  logic                  pull,
  output logic [7:0]            body_data,
  output logic                  body_last,
  output logic                  seg_pull
);
  import net_tx_pkg::*;

  typedef enum logic [1:0]
  {
    IP_IDLE,
    IP_HDR,
    IP_SEG
  } ip_state_e;

  ip_state_e    state;
  logic [4:0]   idx;
  logic [15:0]  ip_id;
  logic [15:0]  hdr_csum;
  len_t         total_len;
  logic [159:0] hdr;
  logic [31:0]  csum_acc;
  logic [16:0]  csum_fold;
  logic [15:0]  csum_next;
  logic         in_seg;

  assign total_len = seg_length + 16'(IP_HDR_LEN);

  // ------------------------------
  // header checksum
  // ------------------------------
  always_comb
  begin
    // checksum word itself counts as zero
    csum_acc = 32'(16'h4500) + 32'(total_len) + 32'(ip_id)
             + 32'({IP_TTL, IP_PROTO_UDP})
             + 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0])
             + 32'(dest_ip[31:16]) + 32'(dest_ip[15:0]);
    // end around carry, twice covers every possible sum
    csum_fold = {1'b0, csum_acc[15:0]} + {1'b0, csum_acc[31:16]};
    csum_next = ~(csum_fold[15:0] + {15'd0, csum_fold[16]});
  end

  // fields are stable from the start pulse on
  always_ff @(posedge tx_clock)
  begin
    if (start)
      hdr_csum <= csum_next;
  end

  // ------------------------------
  // byte stream
  // ------------------------------

  // version/ihl, tos, length, id, flags/offset, ttl, proto, csum, src, dst
  assign hdr = {8'h45, 8'h00, total_len, ip_id, 16'h0000, IP_TTL, IP_PROTO_UDP,
                hdr_csum, LOCAL_IP, dest_ip};

  assign in_seg = (state == IP_SEG);
  assign body_data = in_seg ? seg_data : hdr[8*(19 - idx) +: 8];
  assign body_last = in_seg & seg_last;

  // segment bytes move one for one with the framer
  assign seg_pull = in_seg & pull;

  always_ff @(posedge tx_clock)
  begin
    if (!rst_n)
    begin
      state <= IP_IDLE;
      idx <= '0;
      ip_id <= '0;
    end
    else if (start)
    begin
      state <= IP_HDR;
      idx <= '0;
    end
    else if (pull)
    begin
      if (state == IP_HDR)
      begin
        if (idx == 5'(IP_HDR_LEN - 1))
          state <= IP_SEG;
        else
          idx <= idx + 5'd1;
      end
      else if (body_last)
      begin
        // next datagram gets the next identification
        state <= IP_IDLE;
        ip_id <= ip_id + 16'd1;
      end
    end
  end

endmodule

// File: logic/mac_framer.sv
/* MAC framer, emits destination, source and ethertype ahead of the body,
   one byte per cycle when the credit counter allows */
`timescale 1ns/1ps

module mac_framer
#(
  parameter net_tx_pkg::mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_01,
  parameter int CREDIT_MAX = 8
)
(
  input  logic                   tx_clock,
  input  logic                   rst_n,
  input  logic                   start,
  input  net_tx_pkg::mac_addr_t  dest_mac,
  input  logic [15:0]            ethertype,
  input  logic [7:0]             body_data,
  input  logic                   body_last,
  input  logic                   credit_return,
  output logic                   body_pull,
  output logic [7:0]             frame_data,
  output logic                   frame_valid,
  output logic                   frame_last,
  output logic                   done
);
  import net_tx_pkg::*;

  localparam int CW = $clog2(CREDIT_MAX + 1);

  typedef enum logic [1:0]
  {
    MAC_IDLE,
    MAC_HDR,
    MAC_BODY
  } mac_state_e;

  mac_state_e   state;
  logic [3:0]   idx;
  logic [111:0] hdr;
  logic [CW-1:0] credit;
  logic         send;

  // ------------------------------
  // credit counter
  // ------------------------------

  // a byte goes out only if the cycle starts with credit
  assign send = (state != MAC_IDLE) && (credit != '0);

  always_ff @(posedge tx_clock)
  begin
    if (!rst_n)
      credit <= CW'(CREDIT_MAX);
    else if (send && !credit_return)
      credit <= credit - CW'(1);
    else if (!send && credit_return)
      credit <= credit + CW'(1);
  end

  // ------------------------------
  // byte stream
  // ------------------------------
  assign hdr = {dest_mac, LOCAL_MAC, ethertype};

  assign frame_valid = send;
  assign frame_data = (state == MAC_BODY) ? body_data : hdr[8*(13 - idx) +: 8];

  // body advances only when its byte is actually sent
  assign body_pull = send && (state == MAC_BODY);
  assign frame_last = body_pull & body_last;
  assign done = frame_last;

  always_ff @(posedge tx_clock)
  begin
    if (!rst_n)
    begin
      state <= MAC_IDLE;
      idx <= '0;
    end
    else if (start)
    begin
      state <= MAC_HDR;
      idx <= '0;
    end
    else if (send)
    begin
      if (state == MAC_HDR)
      begin
        if (idx == 4'(MAC_HDR_LEN - 1))
          state <= MAC_BODY;
        else
          idx <= idx + 4'd1;
      end
      else if (body_last)
        state <= MAC_IDLE;
    end
  end

  // receiver returns no more than it took, so the count stays in range
  a_credit_range: assert property (@(posedge tx_clock) disable iff (!rst_n)
    credit <= CW'(CREDIT_MAX));

endmodule

// File: logic/net_tx_top.sv
/* network transmit path, arbitration and UDP/IPv4/MAC framing
   into a byte stream under credit flow control */
`timescale 1ns/1ps

module net_tx_top
#(
  parameter net_tx_pkg::mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_01,
  parameter net_tx_pkg::ip_addr_t  LOCAL_IP = 32'hc0a8_010a,
  parameter net_tx_pkg::port_t     LOCAL_PORT = 16'd1024,
  parameter int CREDIT_MAX = 8
)
(
  input  logic                   tx_clock,
  input  logic                   rst_n,
  input  logic                   arp_request,
  input  net_tx_pkg::mac_addr_t  arp_dest_mac,
  input  logic [7:0]             arp_data,
  output logic                   arp_grant,
  output logic                   arp_advance,
  input  logic                   udp_request,
  input  net_tx_pkg::len_t       udp_length,
  input  net_tx_pkg::ip_addr_t   udp_dest_ip,
  input  net_tx_pkg::mac_addr_t  udp_dest_mac,
  input  net_tx_pkg::port_t      udp_dest_port,
  input  logic [7:0]             udp_data,
  output logic                   udp_grant,
  output logic                   udp_advance,
  input  logic                   credit_return,
  output logic [7:0]             frame_data,
  output logic                   frame_valid,
  output logic                   frame_last
);
  import net_tx_pkg::*;

  // ------------------------------
  // arbiter to stages
  // ------------------------------
  logic        frame_start;
  logic        frame_pull;
  logic        frame_done;
  logic [15:0] frame_ethertype;
  mac_addr_t   frame_dest_mac;
  logic [7:0]  frame_body_data;
  logic        frame_body_last;
  ip_addr_t    dest_ip;
  port_t       dest_port;
  len_t        payload_length;
  logic [7:0]  payload_data;
  logic        payload_pull;
  logic        ip_start;
  logic        ip_pull;

  // ------------------------------
  // udp to ip, ip to arbiter
  // ------------------------------
  logic [7:0]  seg_data;
  logic        seg_last;
  len_t        seg_length;
  logic        seg_pull;
  logic [7:0]  ip_body_data;
  logic        ip_body_last;

  tx_arbiter u_arbiter
  (
    .tx_clock(tx_clock), .rst_n(rst_n),
    .arp_request(arp_request), .arp_dest_mac(arp_dest_mac), .arp_data(arp_data),
    .udp_request(udp_request), .udp_length(udp_length), .udp_dest_ip(udp_dest_ip),
    .udp_dest_mac(udp_dest_mac), .udp_dest_port(udp_dest_port), .udp_data(udp_data),
    .udp_pull(payload_pull), .ip_body_data(ip_body_data), .ip_body_last(ip_body_last),
    .frame_pull(frame_pull), .frame_done(frame_done),
    .arp_grant(arp_grant), .arp_advance(arp_advance),
    .udp_grant(udp_grant), .udp_advance(udp_advance),
    .frame_start(frame_start), .frame_ethertype(frame_ethertype),
    .frame_dest_mac(frame_dest_mac), .frame_body_data(frame_body_data),
    .frame_body_last(frame_body_last), .dest_ip(dest_ip), .dest_port(dest_port),
    .payload_length(payload_length), .payload_data(payload_data),
    .ip_start(ip_start), .ip_pull(ip_pull)
  );

  // udp and ip headers both start on the udp grant
  udp_header #(.LOCAL_PORT(LOCAL_PORT)) u_udp
  (
    .tx_clock(tx_clock), .rst_n(rst_n), .start(ip_start),
    .payload_length(payload_length), .dest_port(dest_port),
    .payload_data(payload_data), .pull(seg_pull),
    .seg_data(seg_data), .seg_last(seg_last), .seg_length(seg_length),
    .payload_advance(payload_pull)
  );

  ip_header #(.LOCAL_IP(LOCAL_IP)) u_ip
  (
    .tx_clock(tx_clock), .rst_n(rst_n), .start(ip_start),
    .seg_length(seg_length), .dest_ip(dest_ip),
    .seg_data(seg_data), .seg_last(seg_last), .pull(ip_pull),
    .body_data(ip_body_data), .body_last(ip_body_last), .seg_pull(seg_pull)
  );

  mac_framer #(.LOCAL_MAC(LOCAL_MAC), .CREDIT_MAX(CREDIT_MAX)) u_mac
  (
    .tx_clock(tx_clock), .rst_n(rst_n), .start(frame_start),
    .dest_mac(frame_dest_mac), .ethertype(frame_ethertype),
    .body_data(frame_body_data), .body_last(frame_body_last),
    .credit_return(credit_return), .body_pull(frame_pull),
    .frame_data(frame_data), .frame_valid(frame_valid),
    .frame_last(frame_last), .done(frame_done)
  );

endmodule

// File: verification/net_tx_model.svh
/* frame model for the network transmit testbench
   builds the expected frame at each grant and checks every sent byte */
`ifndef NET_TX_MODEL_SVH
`define NET_TX_MODEL_SVH

  // ------------------------------
  // expected frames, in grant order
  // ------------------------------
  logic [7:0] exp_bytes[$];
  len_t       exp_len[$];
  mac_addr_t  exp_mac[$];
  len_t       exp_id[$];
  bit         exp_udp[$];

  // identification the DUT should put in the next datagram
  len_t       model_ip_id;

  // frame currently on the output
  len_t       cur_count;
  mac_addr_t  cur_mac;
  len_t       cur_id;

  // per test bookkeeping
  string      test_name;
  int         test_errors;
  int         tests_run;
  int         tests_failed;
  int         total_errors;

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("%-14s %s (%0d errors)", test_name, (test_errors == 0) ? "pass" : "fail",
             test_errors);
    tests_run = tests_run + 1;
    if (test_errors != 0)
      tests_failed = tests_failed + 1;
    total_errors = total_errors + test_errors;
  endtask

  task automatic note_failure(input string msg);
    $display("failure in %s: %s", test_name, msg);
    test_errors = test_errors + 1;
  endtask

  task automatic compare_byte(input string what, input logic [7:0] expected,
                              input logic [7:0] actual);
    if (actual !== expected)
    begin
      $display("error %s: %s expected %02h actual %02h", test_name, what, expected, actual);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic compare_length(input string what, input len_t expected, input len_t actual);
    if (actual !== expected)
    begin
      $display("error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic compare_mac(input string what, input mac_addr_t expected,
                             input mac_addr_t actual);
    if (actual !== expected)
    begin
      $display("error %s: %s expected %012h actual %012h", test_name, what, expected, actual);
      test_errors = test_errors + 1;
    end
  endtask

  // ------------------------------
  // frame builders
  // ------------------------------

  // network byte order, most significant byte first
  task automatic push_exp(input logic [47:0] value, input int n);
    for (int i = n - 1; i >= 0; i--)
      exp_bytes.push_back(value[8*i +: 8]);
  endtask

  task automatic build_arp_frame(input mac_addr_t mac, input logic [7:0] body[$]);
    push_exp(mac, 6);
    push_exp(LOCAL_MAC, 6);
    push_exp(ETHERTYPE_ARP, 2);
    foreach (body[i])
      exp_bytes.push_back(body[i]);
    exp_len.push_back(len_t'(MAC_HDR_LEN + ARP_BODY_LEN));
    exp_mac.push_back(mac);
    exp_id.push_back('0);
    exp_udp.push_back(1'b0);
  endtask

  task automatic build_udp_frame(input mac_addr_t mac, input ip_addr_t ip, input port_t port,
                                 input len_t len, input logic [7:0] payload[$]);
    logic [15:0] w[10];
    logic [31:0] sum;
    len_t        total;
    total = len + len_t'(IP_HDR_LEN + UDP_HDR_LEN);
    // ipv4 header as words, checksum slot (word 5) zero while summing
    w = '{16'h4500, total, model_ip_id, 16'h0000, {IP_TTL, IP_PROTO_UDP}, 16'h0000,
          LOCAL_IP[31:16], LOCAL_IP[15:0], ip[31:16], ip[15:0]};
    sum = '0;
    foreach (w[i])
      sum = sum + {16'd0, w[i]};
    while (sum[31:16] != 16'd0)
      sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    w[5] = ~sum[15:0];
    push_exp(mac, 6);
    push_exp(LOCAL_MAC, 6);
    push_exp(ETHERTYPE_IP, 2);
    foreach (w[i])
      push_exp(w[i], 2);
    // udp header, checksum left at zero
    push_exp(LOCAL_PORT, 2);
    push_exp(port, 2);
    push_exp(len + len_t'(UDP_HDR_LEN), 2);
    push_exp(16'h0000, 2);
    foreach (payload[i])
      exp_bytes.push_back(payload[i]);
    exp_len.push_back(len_t'(MAC_HDR_LEN) + total);
    exp_mac.push_back(mac);
    exp_id.push_back(model_ip_id);
    exp_udp.push_back(1'b1);
    model_ip_id = model_ip_id + 16'd1;
  endtask

  // one sent byte against the head of the expected stream
  task automatic check_frame_byte(input logic [7:0] data, input logic last);
    if (exp_bytes.size() == 0)
    begin
      note_failure("a frame byte was sent while no frame was expected");
      return;
    end
    compare_byte($sformatf("frame byte %0d", cur_count), exp_bytes.pop_front(), data);
    if (cur_count < 16'd6)
      cur_mac = {cur_mac[39:0], data};
    // identification sits at frame bytes 18 and 19
    if (cur_count == 16'd18 || cur_count == 16'd19)
      cur_id = {cur_id[7:0], data};
    cur_count = cur_count + 16'd1;
    if (last !== (cur_count == exp_len[0]))
      note_failure("frame_last does not line up with the end of the frame");
    if (last)
    begin
      compare_length("frame length", exp_len.pop_front(), cur_count);
      compare_mac("destination mac", exp_mac.pop_front(), cur_mac);
      if (exp_udp.pop_front())
        compare_length("ip identification", exp_id[0], cur_id);
      void'(exp_id.pop_front());
      cur_count = '0;
    end
  endtask

`endif

// File: verification/net_tx_tb.sv
/* network transmit testbench, random ARP and UDP requests checked
   against a frame model while a receiver hands credits back late */
`timescale 1ns/1ps

module net_tx_tb;
  import net_tx_pkg::*;

  localparam mac_addr_t LOCAL_MAC = 48'h02_1a_2b_3c_4d_5e;
  localparam ip_addr_t  LOCAL_IP = 32'hc0a8_0164;
  localparam port_t     LOCAL_PORT = 16'd5000;
  localparam int        CREDIT_MAX = 4;
  localparam int        MAX_PAYLOAD = 64;
  localparam int        N_UDP = 12;
  localparam int        N_IDENT = 6;
  localparam int        N_MIX = 16;
  // arp, udp run, ident run, priority pair, mixed run
  localparam int        N_FRAMES = 1 + N_UDP + N_IDENT + 2 + N_MIX;
  localparam int        MAX_FRAME = MAC_HDR_LEN + IP_HDR_LEN + UDP_HDR_LEN + MAX_PAYLOAD;
  localparam real       WATCHDOG_NS = N_FRAMES * MAX_FRAME * 4.0 * 20.0;

  logic       tx_clock;
  logic       rst_n;
  logic       arp_request;
  mac_addr_t  arp_dest_mac;
  logic [7:0] arp_data;
  logic       arp_grant;
  logic       arp_advance;
  logic       udp_request;
  len_t       udp_length;
  ip_addr_t   udp_dest_ip;
  mac_addr_t  udp_dest_mac;
  port_t      udp_dest_port;
  logic [7:0] udp_data;
  logic       udp_grant;
  logic       udp_advance;
  logic       credit_return;
  logic [7:0] frame_data;
  logic       frame_valid;
  logic       frame_last;

  // source byte queues, head is the byte on the bus
  logic [7:0] arp_q[$];
  logic [7:0] udp_q[$];
  bit         arp_busy;
  bit         udp_busy;
  bit         arp_start;
  bit         udp_start;
  // outputs sampled mid cycle
  bit         s_arp_req;
  bit         s_arp_grant;
  bit         s_arp_adv;
  bit         s_udp_grant;
  bit         s_udp_adv;
  bit         frame_open;
  bit         withhold_en;
  int         outstanding;
  int         hold_left;
  int         posted;

  `include "net_tx_model.svh"

  net_tx_top #(.LOCAL_MAC(LOCAL_MAC), .LOCAL_IP(LOCAL_IP), .LOCAL_PORT(LOCAL_PORT),
               .CREDIT_MAX(CREDIT_MAX)) u_dut
  (
    .tx_clock(tx_clock), .rst_n(rst_n),
    .arp_request(arp_request), .arp_dest_mac(arp_dest_mac), .arp_data(arp_data),
    .arp_grant(arp_grant), .arp_advance(arp_advance),
    .udp_request(udp_request), .udp_length(udp_length), .udp_dest_ip(udp_dest_ip),
    .udp_dest_mac(udp_dest_mac), .udp_dest_port(udp_dest_port), .udp_data(udp_data),
    .udp_grant(udp_grant), .udp_advance(udp_advance),
    .credit_return(credit_return), .frame_data(frame_data),
    .frame_valid(frame_valid), .frame_last(frame_last)
  );

  always #2 tx_clock = ~tx_clock;

  // ------------------------------
  // monitor and scoreboard
  // ------------------------------
  always @(negedge tx_clock)
  begin
    if (rst_n === 1'b1)
    begin
      if (arp_grant || udp_grant)
      begin
        if (frame_open)
          note_failure("a new frame was granted before the previous one ended");
        // request seen at the granting edge
        if (udp_grant && s_arp_req)
          note_failure("UDP was granted ahead of a pending ARP request");
        if (arp_grant)
          build_arp_frame(arp_dest_mac, arp_q);
        else
          build_udp_frame(udp_dest_mac, udp_dest_ip, udp_dest_port, udp_length, udp_q);
        frame_open = 1'b1;
      end
      if (frame_valid)
      begin
        if (outstanding >= CREDIT_MAX)
          note_failure("a byte was sent with every credit already taken");
        check_frame_byte(frame_data, frame_last);
        if (frame_last)
          frame_open = 1'b0;
      end
      outstanding = outstanding + (frame_valid ? 1 : 0) - (credit_return ? 1 : 0);
    end
    s_arp_req = arp_request;
    s_arp_grant = arp_grant;
    s_arp_adv = arp_advance;
    s_udp_grant = udp_grant;
    s_udp_adv = udp_advance;
  end

  // ------------------------------
  // sources and credit returner
  // ------------------------------
  always @(posedge tx_clock)
  begin
    #1;
    // fields scrambled after the grant, capture must already be done
    if (s_arp_grant)
    begin
      arp_request = 1'b0;
      arp_dest_mac = {16'($urandom), 32'($urandom)};
    end
    if (s_udp_grant)
    begin
      udp_request = 1'b0;
      udp_length = 16'($urandom);
      udp_dest_ip = $urandom;
      udp_dest_mac = {16'($urandom), 32'($urandom)};
      udp_dest_port = 16'($urandom);
    end
    if (s_arp_adv)
    begin
      if (arp_q.size() == 0)
        note_failure("the ARP body was pulled past its last byte");
      else
        void'(arp_q.pop_front());
      if (arp_q.size() == 0)
        arp_busy = 1'b0;
      else
        arp_data = arp_q[0];
    end
    if (s_udp_adv)
    begin
      if (udp_q.size() == 0)
        note_failure("the UDP payload was pulled past its last byte");
      else
        void'(udp_q.pop_front());
      if (udp_q.size() == 0)
        udp_busy = 1'b0;
      else
        udp_data = udp_q[0];
    end
    if (arp_start)
    begin
      arp_start = 1'b0;
      arp_q.delete();
      repeat (ARP_BODY_LEN)
        arp_q.push_back(8'($urandom));
      arp_dest_mac = {16'($urandom), 32'($urandom)};
      arp_data = arp_q[0];
      arp_request = 1'b1;
    end
    if (udp_start)
    begin
      udp_start = 1'b0;
      udp_q.delete();
      udp_length = 16'(1 + $urandom % MAX_PAYLOAD);
      repeat (udp_length)
        udp_q.push_back(8'($urandom));
      udp_dest_ip = $urandom;
      udp_dest_mac = {16'($urandom), 32'($urandom)};
      udp_dest_port = 16'($urandom);
      udp_data = udp_q[0];
      udp_request = 1'b1;
    end
    // receiver frees bytes at random, with long stalls when enabled
    if (hold_left > 0)
    begin
      hold_left = hold_left - 1;
      credit_return = 1'b0;
    end
    else if (withhold_en && $urandom % 16 == 0)
    begin
      hold_left = 5 + $urandom % 26;
      credit_return = 1'b0;
    end
    else
      credit_return = (outstanding > 0) && ($urandom % 2 == 0);
  end

  task automatic request_arp();
    arp_busy = 1'b1;
    arp_start = 1'b1;
  endtask

  task automatic request_udp();
    udp_busy = 1'b1;
    udp_start = 1'b1;
  endtask

  // until both sources are drained and every expected byte is seen
  task automatic wait_frames();
    @(negedge tx_clock);
    while (arp_busy || udp_busy || exp_bytes.size() != 0)
      @(negedge tx_clock);
    repeat (4) @(negedge tx_clock);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    void'($urandom(32'h51182e52));
    tx_clock = 1'b0;
    rst_n = 1'b0;
    arp_request = 1'b0;
    arp_dest_mac = '0;
    arp_data = '0;
    udp_request = 1'b0;
    udp_length = '0;
    udp_dest_ip = '0;
    udp_dest_mac = '0;
    udp_dest_port = '0;
    udp_data = '0;
    credit_return = 1'b0;
    model_ip_id = '0;
    cur_count = '0;
    cur_mac = '0;
    cur_id = '0;
    repeat (10) @(posedge tx_clock);
    #1;
    rst_n = 1'b1;

    start_test("reset_state");
    repeat (20)
    begin
      @(negedge tx_clock);
      if (frame_valid !== 1'b0)
        note_failure("frame_valid is not low while no request is made");
    end
    end_test();

    start_test("arp_frame");
    request_arp();
    wait_frames();
    end_test();

    start_test("udp_frames");
    repeat (N_UDP)
    begin
      request_udp();
      wait_frames();
    end
    end_test();

    // arp frames in between must leave the identification alone
    start_test("ip_ident");
    for (int i = 0; i < N_IDENT; i++)
    begin
      if (i % 3 == 1)
        request_arp();
      else
        request_udp();
      wait_frames();
    end
    end_test();

    // both raised on the same edge
    start_test("priority");
    request_udp();
    request_arp();
    wait_frames();
    end_test();

    start_test("credit_stress");
    withhold_en = 1'b1;
    posted = 0;
    while (posted < N_MIX)
    begin
      @(negedge tx_clock);
      if (!arp_busy && $urandom % 10 == 0)
      begin
        request_arp();
        posted = posted + 1;
      end
      else if (!udp_busy && $urandom % 3 == 0)
      begin
        request_udp();
        posted = posted + 1;
      end
    end
    wait_frames();
    withhold_en = 1'b0;
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // run length bound from the largest possible frames
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all frames were sent");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: all.f
+incdir+verification
logic/net_tx_pkg.sv
logic/tx_arbiter.sv
logic/udp_header.sv
logic/ip_header.sv
logic/mac_framer.sv
logic/net_tx_top.sv
verification/net_tx_tb.sv
